/* common/spi_pkg.sv */
package spi_pkg;

    localparam int LANES       = 4;
    localparam int SAMPLE_BITS = 16;
    localparam int SCLK_HALF   = 2;  // system clocks per half period of sclk.

    typedef logic [SAMPLE_BITS-1:0] sample_t;

    // lane 0 sits in the low bits so the struct casts to a sample_t array.
    typedef struct packed {
        sample_t lane3;
        sample_t lane2;
        sample_t lane1;
        sample_t lane0;
    } sample_set_t;

    typedef struct packed {
        logic [LANES-1:0] sclk;
        logic [LANES-1:0] cs;    // active low.
        logic [LANES-1:0] mosi;
    } spi_out_t;

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_DONE
    } spi_state_t;

endpackage

/* common/link_pkg.sv */
package link_pkg;

    localparam int BIT_CLKS   = 8;   // system clocks per serial bit.
    localparam int FRAME_BITS = 18;  // start, 16 data bits and stop.

    typedef logic [7:0] byte_t;
    typedef logic [spi_pkg::LANES-1:0] lane_bits_t;

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

/* hw/pin.sv */
`timescale 1ns/1ps

module pin (
    input  logic [spi_pkg::LANES-1:0]  miso_p,
    input  logic [spi_pkg::LANES-1:0]  miso_n,
    output logic [spi_pkg::LANES-1:0]  mosi_p,
    output logic [spi_pkg::LANES-1:0]  mosi_n,
    output logic [spi_pkg::LANES-1:0]  cs_p,
    output logic [spi_pkg::LANES-1:0]  cs_n,
    output logic [spi_pkg::LANES-1:0]  sclk_p,
    output logic [spi_pkg::LANES-1:0]  sclk_n,

    output logic [spi_pkg::LANES-1:0]  com_txd_p,
    output logic [spi_pkg::LANES-1:0]  com_txd_n,
    input  logic [1:0]                 com_rxd_p,
    input  logic [1:0]                 com_rxd_n,

    input  logic                       fire_p,
    input  logic                       fire_n,

    output logic [spi_pkg::LANES-1:0]  miso,
    input  spi_pkg::spi_out_t          spi_bus,
    input  link_pkg::lane_bits_t       pin_txd,
    output logic                       pin_rxd,
    output logic                       fire_read
);

    logic [1:0] com_rxd;

    // a pair with equal legs has no valid level, so it reads as unknown.
    function automatic logic diff_in(input logic p, input logic n);
        return (p != n) ? p : 1'bx;
    endfunction

    genvar i;
    generate
        for (i = 0; i < spi_pkg::LANES; i++) begin : g_lane
            assign miso[i]      = diff_in(miso_p[i], miso_n[i]);

            assign mosi_p[i]    = spi_bus.mosi[i];
            assign mosi_n[i]    = ~spi_bus.mosi[i];

            assign cs_p[i]      = spi_bus.cs[i];
            assign cs_n[i]      = ~spi_bus.cs[i];

            assign sclk_p[i]    = spi_bus.sclk[i];
            assign sclk_n[i]    = ~spi_bus.sclk[i];

            assign com_txd_p[i] = pin_txd[i];
            assign com_txd_n[i] = ~pin_txd[i];
        end

        for (i = 0; i < 2; i++) begin : g_rxd
            assign com_rxd[i] = diff_in(com_rxd_p[i], com_rxd_n[i]);
        end
    endgenerate

    assign pin_rxd   = com_rxd[0];  // only the first receive lane reaches the core.
    assign fire_read = diff_in(fire_p, fire_n);

endmodule

/* spi/spi_array.sv */
`timescale 1ns/1ps

module spi_array (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fire_read,
    input  logic [spi_pkg::LANES-1:0]  miso,
    input  link_pkg::byte_t            cmd_byte,
    input  logic                       tx_busy,
    output spi_pkg::spi_out_t          spi_bus,
    output spi_pkg::sample_set_t       samples,
    output logic                       samples_valid
);

    spi_pkg::spi_state_t                       state;
    logic [$clog2(spi_pkg::SCLK_HALF)-1:0]     half_cnt;
    logic [$clog2(spi_pkg::SAMPLE_BITS)-1:0]   bit_cnt;
    logic                                      sclk;
    logic                                      cs;
    logic                                      fire_prev;
    spi_pkg::sample_t                          mosi_sr;
    spi_pkg::sample_t [spi_pkg::LANES-1:0]     lane_sr;
    logic                                      fire_rise;
    logic                                      half_end;
    logic                                      sclk_rise;

    assign fire_rise = fire_read & ~fire_prev;
    assign half_end  = (half_cnt == spi_pkg::SCLK_HALF - 1);
    assign sclk_rise = (state == spi_pkg::SPI_SHIFT) && half_end && !sclk;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= spi_pkg::SPI_IDLE;
            half_cnt  <= '0;
            bit_cnt   <= '0;
            sclk      <= 1'b0;
            cs        <= 1'b1;
            fire_prev <= 1'b0;
            mosi_sr   <= '0;
        end else begin
            fire_prev <= fire_read;
            case (state)
                spi_pkg::SPI_IDLE: begin
                    // a trigger that arrives while the frame is still going out is dropped.
                    if (fire_rise && !tx_busy) begin
                        state    <= spi_pkg::SPI_SHIFT;
                        cs       <= 1'b0;
                        half_cnt <= '0;
                        bit_cnt  <= '0;
                        mosi_sr  <= {cmd_byte, 8'h00};
                    end
                end
                spi_pkg::SPI_SHIFT: begin
                    half_cnt <= half_end ? '0 : half_cnt + 1'b1;
                    if (half_end) begin
                        sclk <= ~sclk;
                        if (sclk) begin  // falling edge.
                            mosi_sr <= {mosi_sr[spi_pkg::SAMPLE_BITS-2:0], 1'b0};
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == spi_pkg::SAMPLE_BITS - 1) begin
                                state <= spi_pkg::SPI_DONE;
                                cs    <= 1'b1;
                            end
                        end
                    end
                end
                spi_pkg::SPI_DONE: begin
                    state <= spi_pkg::SPI_IDLE;
                end
                default: begin
                    state <= spi_pkg::SPI_IDLE;
                end
            endcase
        end
    end

    // every lane captures its own MISO on the rising edge of the shared sclk.
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            for (int i = 0; i < spi_pkg::LANES; i++) begin
                lane_sr[i] <= {lane_sr[i][spi_pkg::SAMPLE_BITS-2:0], miso[i]};
            end
        end
    end

    always_comb begin
        spi_bus.sclk = {spi_pkg::LANES{sclk}};
        spi_bus.cs   = {spi_pkg::LANES{cs}};
        spi_bus.mosi = {spi_pkg::LANES{mosi_sr[spi_pkg::SAMPLE_BITS-1]}};
    end

    assign samples       = spi_pkg::sample_set_t'(lane_sr);
    assign samples_valid = (state == spi_pkg::SPI_DONE);  // one cycle, with cs already high.

endmodule

/* link/frame_tx.sv */
`timescale 1ns/1ps

module frame_tx (
    input  logic                  clk,
    input  logic                  reset,
    input  spi_pkg::sample_set_t  samples,
    input  logic                  samples_valid,
    output link_pkg::lane_bits_t  pin_txd,
    output logic                  tx_busy
);

    link_pkg::tx_state_t                                    state;
    logic [$clog2(link_pkg::BIT_CLKS)-1:0]                  bit_timer;
    logic [$clog2(link_pkg::FRAME_BITS)-1:0]                bit_cnt;
    logic [spi_pkg::LANES-1:0][link_pkg::FRAME_BITS-1:0]    frame;
    spi_pkg::sample_t [spi_pkg::LANES-1:0]                  lane_data;
    logic                                                   bit_end;

    assign lane_data = samples;
    assign bit_end   = (bit_timer == link_pkg::BIT_CLKS - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= link_pkg::TX_IDLE;
            bit_timer <= '0;
            bit_cnt   <= '0;
            frame     <= '1;  // the lines idle high.
        end else begin
            case (state)
                link_pkg::TX_IDLE: begin
                    if (samples_valid) begin
                        state     <= link_pkg::TX_SEND;
                        bit_timer <= '0;
                        bit_cnt   <= '0;
                        for (int i = 0; i < spi_pkg::LANES; i++) begin
                            frame[i] <= {1'b0, lane_data[i], 1'b1};
                        end
                    end
                end
                link_pkg::TX_SEND: begin
                    bit_timer <= bit_end ? '0 : bit_timer + 1'b1;
                    if (bit_end) begin
                        // ones shift in behind the stop bit, so the lane is idle when done.
                        for (int i = 0; i < spi_pkg::LANES; i++) begin
                            frame[i] <= {frame[i][link_pkg::FRAME_BITS-2:0], 1'b1};
                        end
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == link_pkg::FRAME_BITS - 1) begin
                            state <= link_pkg::TX_IDLE;
                        end
                    end
                end
                default: begin
                    state <= link_pkg::TX_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < spi_pkg::LANES; i++) begin
            pin_txd[i] = frame[i][link_pkg::FRAME_BITS-1];
        end
    end

    assign tx_busy = (state == link_pkg::TX_SEND);

endmodule

/* link/cmd_rx.sv */
`timescale 1ns/1ps

module cmd_rx (
    input  logic             clk,
    input  logic             reset,
    input  logic             pin_rxd,
    output link_pkg::byte_t  cmd_byte
);

    link_pkg::rx_state_t                         state;
    logic                                        rxd_meta;
    logic                                        rxd_sync;
    logic                                        rxd_prev;
    logic [$clog2(link_pkg::BIT_CLKS)-1:0]       timer;
    logic [$clog2($bits(link_pkg::byte_t))-1:0]  bit_cnt;
    link_pkg::byte_t                             shift;
    logic                                        mid_start;
    logic                                        bit_end;

    assign mid_start = (timer == link_pkg::BIT_CLKS / 2 - 1);
    assign bit_end   = (timer == link_pkg::BIT_CLKS - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= link_pkg::RX_IDLE;
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
            timer    <= '0;
            bit_cnt  <= '0;
            cmd_byte <= '0;
        end else begin
            rxd_meta <= pin_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
            timer    <= timer + 1'b1;
            case (state)
                link_pkg::RX_IDLE: begin
                    timer <= '0;
                    if (rxd_prev && !rxd_sync) state <= link_pkg::RX_START;
                end
                link_pkg::RX_START: begin
                    if (mid_start) begin
                        // a glitch shorter than half a bit is not a start bit.
                        state   <= rxd_sync ? link_pkg::RX_IDLE : link_pkg::RX_DATA;
                        timer   <= '0;
                        bit_cnt <= '0;
                    end
                end
                link_pkg::RX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == $bits(link_pkg::byte_t) - 1) state <= link_pkg::RX_STOP;
                    end
                end
                link_pkg::RX_STOP: begin
                    if (bit_end) begin
                        if (rxd_sync) cmd_byte <= shift;  // a framing error keeps the old byte.
                        state <= link_pkg::RX_IDLE;
                    end
                end
                default: state <= link_pkg::RX_IDLE;
            endcase
        end
    end

    // data arrives lsb first.
    always_ff @(posedge clk) begin
        if (state == link_pkg::RX_DATA && bit_end) shift <= {rxd_sync, shift[7:1]};
    end

endmodule

/* hw/sensor_link_top.sv */
`timescale 1ns/1ps

module sensor_link_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [spi_pkg::LANES-1:0]  miso_p,
    input  logic [spi_pkg::LANES-1:0]  miso_n,
    output logic [spi_pkg::LANES-1:0]  mosi_p,
    output logic [spi_pkg::LANES-1:0]  mosi_n,
    output logic [spi_pkg::LANES-1:0]  cs_p,
    output logic [spi_pkg::LANES-1:0]  cs_n,
    output logic [spi_pkg::LANES-1:0]  sclk_p,
    output logic [spi_pkg::LANES-1:0]  sclk_n,
    output logic [spi_pkg::LANES-1:0]  com_txd_p,
    output logic [spi_pkg::LANES-1:0]  com_txd_n,
    input  logic [1:0]                 com_rxd_p,
    input  logic [1:0]                 com_rxd_n,
    input  logic                       fire_p,
    input  logic                       fire_n
);

    logic [spi_pkg::LANES-1:0]  miso;
    spi_pkg::spi_out_t          spi_bus;
    link_pkg::lane_bits_t       pin_txd;
    logic                       pin_rxd;
    logic                       fire_read;
    spi_pkg::sample_set_t       samples;
    logic                       samples_valid;
    logic                       tx_busy;
    link_pkg::byte_t            cmd_byte;

    pin u_pin (
        .miso_p(miso_p), .miso_n(miso_n), .mosi_p(mosi_p), .mosi_n(mosi_n),
        .cs_p(cs_p), .cs_n(cs_n), .sclk_p(sclk_p), .sclk_n(sclk_n),
        .com_txd_p(com_txd_p), .com_txd_n(com_txd_n),
        .com_rxd_p(com_rxd_p), .com_rxd_n(com_rxd_n),
        .fire_p(fire_p), .fire_n(fire_n),
        .miso(miso), .spi_bus(spi_bus), .pin_txd(pin_txd),
        .pin_rxd(pin_rxd), .fire_read(fire_read)
    );

    spi_array u_spi_array (
        .clk(clk), .reset(reset), .fire_read(fire_read), .miso(miso),
        .cmd_byte(cmd_byte), .tx_busy(tx_busy), .spi_bus(spi_bus),
        .samples(samples), .samples_valid(samples_valid)
    );

    frame_tx u_frame_tx (
        .clk(clk), .reset(reset), .samples(samples), .samples_valid(samples_valid),
        .pin_txd(pin_txd), .tx_busy(tx_busy)
    );

    cmd_rx u_cmd_rx (.clk(clk), .reset(reset), .pin_rxd(pin_rxd), .cmd_byte(cmd_byte));

endmodule

/* verif/adc_model.sv */
`timescale 1ns/1ps

module adc_model (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [spi_pkg::LANES-1:0]  cs,
    input  logic [spi_pkg::LANES-1:0]  sclk,
    input  logic [spi_pkg::LANES-1:0]  mosi,
    input  spi_pkg::sample_set_t       preset,
    output logic [spi_pkg::LANES-1:0]  miso,
    output spi_pkg::sample_set_t       mosi_words
);

    spi_pkg::sample_t [spi_pkg::LANES-1:0]  preset_lanes;
    spi_pkg::sample_t [spi_pkg::LANES-1:0]  out_sr;
    spi_pkg::sample_t [spi_pkg::LANES-1:0]  in_sr;
    logic [spi_pkg::LANES-1:0]              cs_prev;
    logic [spi_pkg::LANES-1:0]              sclk_prev;

    assign preset_lanes = preset;
    assign mosi_words   = spi_pkg::sample_set_t'(in_sr);

    // the slaves act on the falling clock, half a cycle away from the master's capture edge.
    always @(negedge clk) begin
        if (reset) begin
            out_sr    <= '0;
            in_sr     <= '0;
            cs_prev   <= '1;
            sclk_prev <= '0;
        end else begin
            for (int i = 0; i < spi_pkg::LANES; i++) begin
                if (cs_prev[i] && !cs[i]) begin
                    out_sr[i] <= preset_lanes[i];  // bit 15 shows as soon as cs falls.
                end else if (!cs[i] && sclk_prev[i] && !sclk[i]) begin
                    out_sr[i] <= {out_sr[i][spi_pkg::SAMPLE_BITS-2:0], 1'b0};
                end
                if (!cs[i] && !sclk_prev[i] && sclk[i]) begin
                    in_sr[i] <= {in_sr[i][spi_pkg::SAMPLE_BITS-2:0], mosi[i]};
                end
            end
            cs_prev   <= cs;
            sclk_prev <= sclk;
        end
    end

    always_comb begin
        for (int i = 0; i < spi_pkg::LANES; i++) begin
            miso[i] = out_sr[i][spi_pkg::SAMPLE_BITS-1];
        end
    end

endmodule

/* verif/tb_sensor_link.sv */
`timescale 1ns/1ps

module tb_sensor_link;

    localparam int LIMIT    = 1000;  // clocks allowed for any single wait.
    localparam int CS_CLKS  = spi_pkg::SAMPLE_BITS * 2 * spi_pkg::SCLK_HALF;
    localparam int BIT_CLKS = link_pkg::BIT_CLKS;
    localparam int FBITS    = link_pkg::FRAME_BITS;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       fire_p;
    logic [1:0]                 rxd_p;
    logic [spi_pkg::LANES-1:0]  adc_miso;
    logic [spi_pkg::LANES-1:0]  mosi_p;
    logic [spi_pkg::LANES-1:0]  mosi_n;
    logic [spi_pkg::LANES-1:0]  cs_p;
    logic [spi_pkg::LANES-1:0]  cs_n;
    logic [spi_pkg::LANES-1:0]  sclk_p;
    logic [spi_pkg::LANES-1:0]  sclk_n;
    logic [spi_pkg::LANES-1:0]  txd_p;
    logic [spi_pkg::LANES-1:0]  txd_n;
    logic [spi_pkg::LANES-1:0]  cs_last;
    spi_pkg::sample_set_t       preset;
    spi_pkg::sample_set_t       mosi_words;
    spi_pkg::sample_t           word_q[$];
    int                         lane_q[$];
    int                         seed = 71;
    int                         cs_falls;
    int                         cs_low_clks;
    link_pkg::byte_t            cmd;

    always #2 clk = ~clk;  // 4 ns period.

    sensor_link_top UUT (
        .clk(clk), .reset(reset), .miso_p(adc_miso), .miso_n(~adc_miso),
        .mosi_p(mosi_p), .mosi_n(mosi_n), .cs_p(cs_p), .cs_n(cs_n),
        .sclk_p(sclk_p), .sclk_n(sclk_n), .com_txd_p(txd_p), .com_txd_n(txd_n),
        .com_rxd_p(rxd_p), .com_rxd_n(~rxd_p), .fire_p(fire_p), .fire_n(~fire_p)
    );

    adc_model adc (
        .clk(clk), .reset(reset), .cs(cs_p), .sclk(sclk_p), .mosi(mosi_p),
        .preset(preset), .miso(adc_miso), .mosi_words(mosi_words)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
            else fail_run($sformatf("Error at %0t ns: %s expected %0h, actual %0h",
                                    $time, name, expected, actual));
    endtask

    // each lane carries its ADC sample unchanged.
    function automatic spi_pkg::sample_t expect_frame(input int lane);
        spi_pkg::sample_t [spi_pkg::LANES-1:0] lanes;
        lanes = preset;
        return lanes[lane];
    endfunction

    function automatic spi_pkg::sample_t expect_mosi(input link_pkg::byte_t value);
        return {value, 8'h00};
    endfunction

    always @(negedge clk) begin
        int               lane;
        spi_pkg::sample_t word;
        while (word_q.size() != 0) begin
            word = word_q.pop_front();
            lane = lane_q.pop_front();
            check_value($sformatf("com_txd_p[%0d] data", lane), expect_frame(lane), word);
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            assert ((mosi_p ^ mosi_n) === '1 && (cs_p ^ cs_n) === '1 &&
                    (sclk_p ^ sclk_n) === '1 && (txd_p ^ txd_n) === '1)
                else fail_run("an output pair has p and n legs that are not complementary");
            if (cs_p === '0) begin
                if (cs_last === '1) cs_falls++;
                cs_low_clks++;
            end else if (cs_last === '0) begin
                check_value("cs_p low clocks", CS_CLKS, cs_low_clks);
                cs_low_clks = 0;
            end
            cs_last = cs_p;
        end
    end

    // finds the start bit, takes each bit at mid-bit and requires it to hold for a bit time.
    task automatic receive_frame(input int lane);
        logic [FBITS-1:0]    bits;
        logic [BIT_CLKS-1:0] held;
        for (int n = 0; txd_p[lane] !== 1'b0; n++) begin
            if (n == LIMIT) fail_run($sformatf("no start bit seen on TXD lane %0d", lane));
            else @(negedge clk);
        end
        for (int k = FBITS - 1; k >= 0; k--) begin
            for (int j = 0; j < BIT_CLKS; j++) begin
                held[j] = txd_p[lane];
                @(negedge clk);
            end
            bits[k] = held[BIT_CLKS/2];
            assert (held === '0 || held === '1)
                else fail_run($sformatf("TXD lane %0d bit %0d did not hold for %0d clocks",
                                        lane, FBITS - 1 - k, BIT_CLKS));
        end
        check_value($sformatf("com_txd_p[%0d] stop bit", lane), 1, bits[0]);
        word_q.push_back(bits[FBITS-2:1]);
        lane_q.push_back(lane);
    endtask

    task automatic receive_all();
        fork
            receive_frame(0);
            receive_frame(1);
            receive_frame(2);
            receive_frame(3);
        join
        for (int n = 0; word_q.size() != 0; n++) begin
            if (n == LIMIT) fail_run("decoded TXD words were never compared");
            else @(negedge clk);
        end
    endtask

    task automatic pulse_fire();
        fire_p = 1'b1;
        repeat (2) @(negedge clk);
        fire_p = 1'b0;
        @(negedge clk);
    endtask

    // 8N1, lsb first, then two idle bit times.
    task automatic send_byte(input link_pkg::byte_t value, input logic stop);
        logic [9:0] frame;
        frame = {stop, value, 1'b0};
        for (int k = 0; k < 10; k++) begin
            rxd_p[0] = frame[k];
            repeat (BIT_CLKS) @(negedge clk);
        end
        rxd_p[0] = 1'b1;
        repeat (2 * BIT_CLKS) @(negedge clk);
    endtask

    task automatic load_presets();
        spi_pkg::sample_t [spi_pkg::LANES-1:0] lanes;
        for (int i = 0; i < spi_pkg::LANES; i++) begin
            lanes[i] = $random(seed);
        end
        preset = lanes;
    endtask

    task automatic check_mosi(input link_pkg::byte_t value);
        spi_pkg::sample_t [spi_pkg::LANES-1:0] words;
        words = mosi_words;
        for (int i = 0; i < spi_pkg::LANES; i++) begin
            check_value($sformatf("mosi_p[%0d] word", i), expect_mosi(value), words[i]);
        end
    endtask

    initial begin
        int falls;
        reset       = 1'b1;
        fire_p      = 1'b0;
        rxd_p       = 2'b11;
        cs_last     = '1;
        cs_falls    = 0;
        cs_low_clks = 0;
        load_presets();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_value("cs_p", {spi_pkg::LANES{1'b1}}, cs_p);
        check_value("sclk_p", 0, sclk_p);
        check_value("mosi_p", 0, mosi_p);
        check_value("com_txd_p", {spi_pkg::LANES{1'b1}}, txd_p);

        pulse_fire();
        receive_all();
        check_mosi(8'h00);  // command byte still at its reset value.
        check_value("cs_p falling edges", 1, cs_falls);

        cmd = $random(seed);
        send_byte(cmd, 1'b1);
        load_presets();
        pulse_fire();
        receive_all();
        check_mosi(cmd);

        // a framing error must leave the previous byte in place.
        send_byte(~cmd, 1'b0);
        pulse_fire();
        receive_all();
        check_mosi(cmd);

        falls = cs_falls;
        pulse_fire();
        fork
            receive_all();
            begin
                repeat (100) @(negedge clk);
                pulse_fire();  // lands while the frame is going out.
            end
        join
        repeat (200) begin
            assert (cs_p === '1 && txd_p === '1)
                else fail_run("CS or TXD became active after a fire pulse that should be dropped");
            @(negedge clk);
        end
        check_value("cs_p falling edges", falls + 1, cs_falls);

        load_presets();
        pulse_fire();
        receive_all();
        check_value("cs_p falling edges", falls + 2, cs_falls);

        $display("Done: no errors");
        $finish;
    end

endmodule

/* sensor_link.f */
common/spi_pkg.sv
common/link_pkg.sv
hw/pin.sv
spi/spi_array.sv
link/frame_tx.sv
link/cmd_rx.sv
hw/sensor_link_top.sv
verif/adc_model.sv
verif/tb_sensor_link.sv
